// File: hdl/isaPkg.sv
package isaPkg;

	localparam int dataW = 16;
	localparam int regAddrW = 3;
	localparam int opW = 4;
	localparam int immW = 6;

	// Codes 9 to 15 are illegal
	typedef enum logic [opW-1:0] {
		opAdd  = 4'h0,
		opSub  = 4'h1,
		opAnd  = 4'h2,
		opXor  = 4'h3,
		opAddi = 4'h4,
		opLd   = 4'h5,
		opSt   = 4'h6,
		opBeqz = 4'h7,
		opHalt = 4'h8
	} opT;

	// Both formats share op, rd and rs in the same positions
	typedef union packed {
		struct packed {
			opT                  op;
			logic [regAddrW-1:0] rd;
			logic [regAddrW-1:0] rs;
			logic [regAddrW-1:0] rt;
			logic [2:0]          unused;
		} rType;
		struct packed {
			opT                     op;
			logic [regAddrW-1:0]    rd;
			logic [regAddrW-1:0]    rs;
			logic signed [immW-1:0] imm;
		} iType;
	} instrWordT;

endpackage

// File: hdl/memPkg.sv
package memPkg;

	localparam int addrW = 8;
	localparam int memDepth = 2 ** addrW;

	// Upper half of memory holds data
	localparam logic [addrW-1:0] dataBase = addrW'(memDepth / 2);

	// Fetch is requester 0, the memory stage requester 1
	localparam int nReq = 2;

endpackage

// File: hdl/fetch.sv
module fetch (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     run,
	input  logic                     stall,
	input  logic                     redirect,
	input  logic [memPkg::addrW-1:0] redirectPc,
	output isaPkg::instrWordT        instr,
	output logic [memPkg::addrW-1:0] instrPc,
	output logic                     instrValid,
	output logic                     req,
	output logic [memPkg::addrW-1:0] addr,
	input  logic                     ack,
	input  logic [isaPkg::dataW-1:0] rdata,
	input  logic                     stop
);

	logic [memPkg::addrW-1:0] pc;
	logic [memPkg::addrW-1:0] fetchPc;
	logic dropQ;
	logic discardQ;
	logic issue;

	// Only fetch into an empty slot, so a result always has somewhere to land
	assign issue = run && !stop && !instrValid;
	assign addr = fetchPc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			req <= 1'b0;
			dropQ <= 1'b0;
			discardQ <= 1'b0;
			instrValid <= 1'b0;
		end else begin
			if (redirect || !stall)
				instrValid <= 1'b0;
			if (redirect)
				pc <= redirectPc;
			if (req && ack) begin
				req <= 1'b0;
				dropQ <= 1'b1;
				discardQ <= 1'b0;
				if (!discardQ && !redirect) begin
					instrValid <= 1'b1;
					pc <= fetchPc + 1'b1;
				end
			end else if (req) begin
				// Wrong-path fetch still finishes its handshake
				if (redirect)
					discardQ <= 1'b1;
			end else if (dropQ) begin
				if (!ack)
					dropQ <= 1'b0;
			end else if (issue) begin
				req <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req && ack) begin
			instr <= rdata;
			instrPc <= fetchPc;
		end
		if (!req && !dropQ && issue)
			fetchPc <= redirect ? redirectPc : pc;
	end

endmodule

// File: hdl/decode.sv
module decode (
	input  logic                        clk,
	input  logic                        rst,
	input  isaPkg::instrWordT           instr,
	input  logic [memPkg::addrW-1:0]    instrPc,
	input  logic                        instrValid,
	input  logic                        flush,
	input  logic [isaPkg::regAddrW-1:0] exRd,
	input  logic                        exWrites,
	input  logic [isaPkg::regAddrW-1:0] memRd,
	input  logic                        memWrites,
	input  logic                        wbEn,
	input  logic [isaPkg::regAddrW-1:0] wbReg,
	input  logic [isaPkg::dataW-1:0]    wbData,
	output logic                        stall,
	output isaPkg::opT                  op,
	output logic [isaPkg::regAddrW-1:0] rd,
	output logic [isaPkg::dataW-1:0]    srcA,
	output logic [isaPkg::dataW-1:0]    srcB,
	output logic [isaPkg::dataW-1:0]    imm,
	output logic [memPkg::addrW-1:0]    pc,
	output logic                        valid,
	input  logic                        downstreamBusy
);

	isaPkg::opT opIn;
	logic [isaPkg::regAddrW-1:0] idxA;
	logic [isaPkg::regAddrW-1:0] idxB;
	logic [isaPkg::dataW-1:0] regs [2 ** isaPkg::regAddrW];
	logic [isaPkg::dataW-1:0] valA;
	logic [isaPkg::dataW-1:0] valB;
	logic [isaPkg::dataW-1:0] immExt;
	logic useA;
	logic useB;
	logic hitA;
	logic hitB;
	logic hazard;
	logic take;
	logic haltIssued;

	assign opIn = instr.rType.op;

	// BEQZ tests rd and ST stores rd
	assign idxA = (opIn == isaPkg::opBeqz) ? instr.iType.rd : instr.iType.rs;
	assign idxB = (opIn == isaPkg::opSt) ? instr.iType.rd : instr.rType.rt;
	assign useA = opIn != isaPkg::opHalt;
	assign useB = opIn inside {isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd,
		isaPkg::opXor, isaPkg::opSt};

	assign valA = (wbEn && wbReg == idxA) ? wbData : regs[idxA];
	assign valB = (wbEn && wbReg == idxB) ? wbData : regs[idxB];
	assign immExt = {{(isaPkg::dataW - isaPkg::immW){instr.iType.imm[isaPkg::immW-1]}},
		instr.iType.imm};

	// A writer retiring this cycle is covered by the write-through
	assign hitA = useA && ((exWrites && exRd == idxA) ||
		(memWrites && !wbEn && memRd == idxA));
	assign hitB = useB && ((exWrites && exRd == idxB) ||
		(memWrites && !wbEn && memRd == idxB));
	assign hazard = instrValid && (hitA || hitB);

	// Nothing past a HALT enters execute
	assign take = instrValid && !hazard && !haltIssued;
	assign stall = hazard || downstreamBusy || haltIssued;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
			haltIssued <= 1'b0;
			for (int i = 0; i < 2 ** isaPkg::regAddrW; i++)
				regs[i] <= '0;
		end else begin
			if (wbEn)
				regs[wbReg] <= wbData;
			if (flush) begin
				valid <= 1'b0;
			end else if (!downstreamBusy) begin
				valid <= take;
				if (take && opIn == isaPkg::opHalt)
					haltIssued <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!downstreamBusy) begin
			op <= opIn;
			rd <= instr.iType.rd;
			srcA <= valA;
			srcB <= valB;
			imm <= immExt;
			pc <= instrPc;
		end
	end

endmodule

// File: hdl/execute.sv
module execute (
	input  logic                        clk,
	input  logic                        rst,
	input  isaPkg::opT                  op,
	input  logic [isaPkg::regAddrW-1:0] rd,
	input  logic [isaPkg::dataW-1:0]    srcA,
	input  logic [isaPkg::dataW-1:0]    srcB,
	input  logic [isaPkg::dataW-1:0]    imm,
	input  logic [memPkg::addrW-1:0]    pc,
	input  logic                        valid,
	input  logic                        busy,
	output logic                        redirect,
	output logic [memPkg::addrW-1:0]    redirectPc,
	output logic                        err,
	output isaPkg::opT                  mOp,
	output logic [isaPkg::regAddrW-1:0] mRd,
	output logic [isaPkg::dataW-1:0]    result,
	output logic [isaPkg::dataW-1:0]    storeData,
	output logic                        mValid,
	output logic                        writes
);

	logic [isaPkg::dataW-1:0] sum;
	logic [memPkg::addrW-1:0] ea;
	logic [isaPkg::dataW-1:0] aluOut;
	logic legal;
	logic writesOp;

	assign sum = srcA + imm;
	// Force every data access into the data segment
	assign ea = memPkg::dataBase | {1'b0, sum[memPkg::addrW-2:0]};

	always_comb begin
		aluOut = '0;
		legal = 1'b1;
		writesOp = 1'b0;
		case (op)
			isaPkg::opAdd: begin
				aluOut = srcA + srcB;
				writesOp = 1'b1;
			end
			isaPkg::opSub: begin
				aluOut = srcA - srcB;
				writesOp = 1'b1;
			end
			isaPkg::opAnd: begin
				aluOut = srcA & srcB;
				writesOp = 1'b1;
			end
			isaPkg::opXor: begin
				aluOut = srcA ^ srcB;
				writesOp = 1'b1;
			end
			isaPkg::opAddi: begin
				aluOut = sum;
				writesOp = 1'b1;
			end
			isaPkg::opLd: begin
				aluOut = isaPkg::dataW'(ea);
				writesOp = 1'b1;
			end
			isaPkg::opSt: aluOut = isaPkg::dataW'(ea);
			isaPkg::opBeqz, isaPkg::opHalt: ;
			default: legal = 1'b0;
		endcase
	end

	assign writes = valid && writesOp;
	assign redirect = valid && !busy && !err && op == isaPkg::opBeqz && srcA == '0;
	assign redirectPc = pc + 1'b1 + imm[memPkg::addrW-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			mValid <= 1'b0;
			err <= 1'b0;
		end else begin
			if (valid && !legal)
				err <= 1'b1;
			// After a trap nothing more reaches memStage
			if (!busy)
				mValid <= valid && legal && !err;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy) begin
			mOp <= op;
			mRd <= rd;
			result <= aluOut;
			storeData <= srcB;
		end
	end

endmodule

// File: hdl/memStage.sv
module memStage (
	input  logic                        clk,
	input  logic                        rst,
	input  isaPkg::opT                  mOp,
	input  logic [isaPkg::regAddrW-1:0] mRd,
	input  logic [isaPkg::dataW-1:0]    result,
	input  logic [isaPkg::dataW-1:0]    storeData,
	input  logic                        mValid,
	output logic                        busy,
	output logic                        writes,
	output logic                        wbEn,
	output logic [isaPkg::regAddrW-1:0] wbReg,
	output logic [isaPkg::dataW-1:0]    wbData,
	output logic                        halted,
	output logic                        req,
	output logic [memPkg::addrW-1:0]    addr,
	output logic                        we,
	output logic [isaPkg::dataW-1:0]    wdata,
	input  logic                        ack,
	input  logic [isaPkg::dataW-1:0]    rdata
);

	logic isLd;
	logic isMem;
	logic done;
	logic dropQ;

	assign isLd = mOp == isaPkg::opLd;
	assign isMem = mValid && (isLd || mOp == isaPkg::opSt);
	assign done = req && ack;
	assign busy = isMem && !done;

	assign writes = mValid && (isLd || mOp inside {isaPkg::opAdd, isaPkg::opSub,
		isaPkg::opAnd, isaPkg::opXor, isaPkg::opAddi});
	// Loads retire on the data ack, ALU results right away
	assign wbEn = writes && (!isLd || done);
	assign wbReg = mRd;
	assign wbData = isLd ? rdata : result;

	assign addr = result[memPkg::addrW-1:0];
	assign we = mOp == isaPkg::opSt;
	assign wdata = storeData;

	always_ff @(posedge clk) begin
		if (rst) begin
			req <= 1'b0;
			dropQ <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (req) begin
				if (ack) begin
					req <= 1'b0;
					dropQ <= 1'b1;
				end
			end else if (dropQ) begin
				if (!ack)
					dropQ <= 1'b0;
			end else if (isMem) begin
				req <= 1'b1;
			end
			if (mValid && mOp == isaPkg::opHalt)
				halted <= 1'b1;
		end
	end

endmodule

// File: hdl/memArbiter.sv
module memArbiter (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     loadEn,
	input  logic [memPkg::addrW-1:0] loadAddr,
	input  logic [isaPkg::dataW-1:0] loadData,
	input  logic                     req0,
	input  logic [memPkg::addrW-1:0] addr0,
	input  logic                     we0,
	input  logic [isaPkg::dataW-1:0] wdata0,
	output logic                     ack0,
	output logic [isaPkg::dataW-1:0] rdata0,
	input  logic                     req1,
	input  logic [memPkg::addrW-1:0] addr1,
	input  logic                     we1,
	input  logic [isaPkg::dataW-1:0] wdata1,
	output logic                     ack1,
	output logic [isaPkg::dataW-1:0] rdata1
);

	logic [isaPkg::dataW-1:0] mem [memPkg::memDepth];
	logic [memPkg::nReq-1:0] reqVec;
	logic grantQ;
	logic ackQ;
	logic selQ;
	logic [memPkg::addrW-1:0] addrSel;
	logic weSel;
	logic [isaPkg::dataW-1:0] wdataSel;
	logic [isaPkg::dataW-1:0] rdQ;

	assign reqVec = {req1, req0};
	assign addrSel = selQ ? addr1 : addr0;
	assign weSel = selQ ? we1 : we0;
	assign wdataSel = selQ ? wdata1 : wdata0;

	assign ack0 = ackQ && !selQ;
	assign ack1 = ackQ && selQ;
	assign rdata0 = rdQ;
	assign rdata1 = rdQ;

	// Idle, then grant, then hold ack until the requester lets go
	always_ff @(posedge clk) begin
		if (rst) begin
			grantQ <= 1'b0;
			ackQ <= 1'b0;
			selQ <= 1'b0;
		end else if (ackQ) begin
			if (!reqVec[selQ])
				ackQ <= 1'b0;
		end else if (grantQ) begin
			grantQ <= 1'b0;
			ackQ <= 1'b1;
		end else if (|reqVec) begin
			grantQ <= 1'b1;
			// memStage holds the older instruction and wins
			selQ <= reqVec[1];
		end
	end

	always_ff @(posedge clk) begin
		if (loadEn)
			mem[loadAddr] <= loadData;
		else if (grantQ && weSel)
			mem[addrSel] <= wdataSel;
		if (grantQ)
			rdQ <= mem[addrSel];
	end

endmodule

// File: hdl/proc.sv
module proc (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        loadEn,
	input  logic [memPkg::addrW-1:0]    loadAddr,
	input  logic [isaPkg::dataW-1:0]    loadData,
	input  logic                        run,
	output logic                        halted,
	output logic                        err,
	output logic                        retireValid,
	output logic [isaPkg::regAddrW-1:0] retireReg,
	output logic [isaPkg::dataW-1:0]    retireData
);

	isaPkg::instrWordT instrF;
	logic [memPkg::addrW-1:0] instrPcF;
	logic instrValidF;
	logic stallD;
	logic redirect;
	logic [memPkg::addrW-1:0] redirectPc;
	logic fetchReq;
	logic fetchAck;
	logic [memPkg::addrW-1:0] fetchAddr;
	logic [isaPkg::dataW-1:0] fetchRdata;

	isaPkg::opT opE;
	logic [isaPkg::regAddrW-1:0] rdE;
	logic [isaPkg::dataW-1:0] srcAE;
	logic [isaPkg::dataW-1:0] srcBE;
	logic [isaPkg::dataW-1:0] immE;
	logic [memPkg::addrW-1:0] pcE;
	logic validE;
	logic exWrites;

	isaPkg::opT mOp;
	logic [isaPkg::regAddrW-1:0] mRd;
	logic [isaPkg::dataW-1:0] result;
	logic [isaPkg::dataW-1:0] storeData;
	logic mValid;
	logic memBusy;
	logic memWrites;
	logic haltedM;
	logic dataReq;
	logic dataAck;
	logic dataWe;
	logic [memPkg::addrW-1:0] dataAddr;
	logic [isaPkg::dataW-1:0] dataWdata;
	logic [isaPkg::dataW-1:0] dataRdata;

	assign halted = haltedM | err;

	fetch fetchStage (
		.clk(clk), .rst(rst), .run(run), .stall(stallD),
		.redirect(redirect), .redirectPc(redirectPc),
		.instr(instrF), .instrPc(instrPcF), .instrValid(instrValidF),
		.req(fetchReq), .addr(fetchAddr), .ack(fetchAck), .rdata(fetchRdata),
		.stop(halted)
	);

	decode decodeStage (
		.clk(clk), .rst(rst), .instr(instrF), .instrPc(instrPcF),
		.instrValid(instrValidF), .flush(redirect),
		.exRd(rdE), .exWrites(exWrites), .memRd(mRd), .memWrites(memWrites),
		.wbEn(retireValid), .wbReg(retireReg), .wbData(retireData),
		.stall(stallD), .op(opE), .rd(rdE), .srcA(srcAE), .srcB(srcBE),
		.imm(immE), .pc(pcE), .valid(validE), .downstreamBusy(memBusy)
	);

	execute executeStage (
		.clk(clk), .rst(rst), .op(opE), .rd(rdE), .srcA(srcAE), .srcB(srcBE),
		.imm(immE), .pc(pcE), .valid(validE), .busy(memBusy),
		.redirect(redirect), .redirectPc(redirectPc), .err(err),
		.mOp(mOp), .mRd(mRd), .result(result), .storeData(storeData),
		.mValid(mValid), .writes(exWrites)
	);

	memStage memoryStage (
		.clk(clk), .rst(rst), .mOp(mOp), .mRd(mRd), .result(result),
		.storeData(storeData), .mValid(mValid), .busy(memBusy), .writes(memWrites),
		.wbEn(retireValid), .wbReg(retireReg), .wbData(retireData), .halted(haltedM),
		.req(dataReq), .addr(dataAddr), .we(dataWe), .wdata(dataWdata),
		.ack(dataAck), .rdata(dataRdata)
	);

	// Program loading only while the core is stopped
	memArbiter arbiter (
		.clk(clk), .rst(rst), .loadEn(loadEn & ~run), .loadAddr(loadAddr),
		.loadData(loadData),
		.req0(fetchReq), .addr0(fetchAddr), .we0(1'b0), .wdata0('0),
		.ack0(fetchAck), .rdata0(fetchRdata),
		.req1(dataReq), .addr1(dataAddr), .we1(dataWe), .wdata1(dataWdata),
		.ack1(dataAck), .rdata1(dataRdata)
	);

endmodule

// File: tb/procArb_assert.sv
module procArb_assert (
	input logic clk,
	input logic rst,
	input logic req0,
	input logic ack0,
	input logic req1,
	input logic ack1
);
	timeunit 1ns;
	timeprecision 100ps;

	int nFail = 0;

	// An ack only answers a request that is still up
	ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
		!(($rose(ack0) && !req0) || ($rose(ack1) && !req1)))
		else begin
			$error("ack rose while its req was low");
			nFail++;
		end

	// A new request waits until the previous ack has gone
	reqAfterAckLow: assert property (@(posedge clk) disable iff (rst)
		!(($rose(req0) && ack0) || ($rose(req1) && ack1)))
		else begin
			$error("req raised again before its ack dropped");
			nFail++;
		end

	// A pending request is never withdrawn before its ack
	reqHeld: assert property (@(posedge clk) disable iff (rst)
		!(($past(req0 && !ack0) && !req0) || ($past(req1 && !ack1) && !req1)))
		else begin
			$error("req dropped before its ack");
			nFail++;
		end

endmodule

bind memArbiter procArb_assert arbChecks (
	.clk(clk), .rst(rst), .req0(req0), .ack0(ack0), .req1(req1), .ack1(ack1)
);

// File: tb/procChecker.sv
module procChecker (
	input  logic                        clk,
	input  logic                        run,
	input  logic                        loadEn,
	input  logic [memPkg::addrW-1:0]    loadAddr,
	input  logic [isaPkg::dataW-1:0]    loadData,
	input  logic                        halted,
	input  logic                        err,
	input  logic                        retireValid,
	input  logic [isaPkg::regAddrW-1:0] retireReg,
	input  logic [isaPkg::dataW-1:0]    retireData,
	output int                          nChecks,
	output int                          nMismatch,
	output int                          nOther
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [isaPkg::dataW-1:0] image [memPkg::memDepth];
	logic [isaPkg::regAddrW-1:0] expReg [$];
	logic [isaPkg::dataW-1:0] expData [$];
	logic expErr = 1'b0;
	logic runQ = 1'b0;

	// Step the ISA over the loaded image and queue every register write
	function automatic void buildTrace();
		logic [isaPkg::dataW-1:0] mem [memPkg::memDepth];
		logic [isaPkg::dataW-1:0] r [8];
		logic [7:0] pc;
		logic [15:0] w;
		logic [15:0] imm;
		logic [15:0] val;
		logic [7:0] ea;
		logic [3:0] op;
		logic [2:0] rd;
		logic [2:0] rs;
		logic [2:0] rt;
		bit wr;
		bit done;
		int steps;
		mem = image;
		for (int i = 0; i < 8; i++)
			r[i] = '0;
		pc = '0;
		done = 1'b0;
		steps = 0;
		expErr = 1'b0;
		expReg.delete();
		expData.delete();
		while (!done && steps < 1000) begin
			w = mem[pc];
			op = w[15:12];
			rd = w[11:9];
			rs = w[8:6];
			rt = w[5:3];
			imm = {{10{w[5]}}, w[5:0]};
			ea = {1'b1, 7'(r[rs] + imm)};
			pc = pc + 8'd1;
			wr = 1'b0;
			val = '0;
			steps++;
			case (op)
				isaPkg::opAdd: begin
					val = r[rs] + r[rt];
					wr = 1'b1;
				end
				isaPkg::opSub: begin
					val = r[rs] - r[rt];
					wr = 1'b1;
				end
				isaPkg::opAnd: begin
					val = r[rs] & r[rt];
					wr = 1'b1;
				end
				isaPkg::opXor: begin
					val = r[rs] ^ r[rt];
					wr = 1'b1;
				end
				isaPkg::opAddi: begin
					val = r[rs] + imm;
					wr = 1'b1;
				end
				isaPkg::opLd: begin
					val = mem[ea];
					wr = 1'b1;
				end
				isaPkg::opSt: mem[ea] = r[rd];
				isaPkg::opBeqz: if (r[rd] == '0) pc = pc + imm[7:0];
				isaPkg::opHalt: done = 1'b1;
				default: begin
					expErr = 1'b1;
					done = 1'b1;
				end
			endcase
			if (wr) begin
				expReg.push_back(rd);
				expData.push_back(val);
				r[rd] = val;
			end
		end
		if (!done) begin
			nOther++;
			$display("Reference model did not reach HALT within %0d steps", steps);
		end
	endfunction

	initial begin
		nChecks = 0;
		nMismatch = 0;
		nOther = 0;
	end

	always @(posedge clk) begin
		if (loadEn && !run)
			image[loadAddr] = loadData;
		if (run && !runQ) begin
			if (halted !== 1'b0 || err !== 1'b0 || retireValid !== 1'b0) begin
				nOther++;
				$display("%0t: core status not clear after reset at start of run", $time);
			end
			buildTrace();
		end
		if (retireValid === 1'b1) begin
			if (halted && !expErr) begin
				nOther++;
				$display("%0t: register write retired after HALT", $time);
			end
			if (expReg.size() == 0) begin
				nOther++;
				$display("%0t: unexpected extra retirement to r%0d", $time, retireReg);
			end else begin
				nChecks++;
				if (retireReg !== expReg[0]) begin
					nMismatch++;
					$display("MISMATCH time=%0t signal=retireReg expected=%0d actual=%0d",
						$time, expReg[0], retireReg);
				end
				if (retireData !== expData[0]) begin
					nMismatch++;
					$display("MISMATCH time=%0t signal=retireData expected=%h actual=%h",
						$time, expData[0], retireData);
				end
				void'(expReg.pop_front());
				void'(expData.pop_front());
			end
		end
		// End of a program
		if (!run && runQ) begin
			if (expReg.size() != 0) begin
				nOther++;
				$display("%0t: %0d expected retirements never happened", $time, expReg.size());
			end
			if (halted !== 1'b1) begin
				nOther++;
				$display("%0t: core is not halted at end of program", $time);
			end
			if (err !== expErr) begin
				nOther++;
				$display("%0t: err is %b but the model expects %b", $time, err, expErr);
			end
		end
		runQ <= run;
	end

endmodule

// File: tb/procTb.sv
module procTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int nProgs = 20;
	localparam int progWords = 48;
	localparam int bodyWords = 40;
	localparam int illegalProg = 7;
	localparam int watchdogNs = nProgs * progWords * 40 * 10;

	logic clk;
	logic rst;
	logic loadEn;
	logic run;
	logic [memPkg::addrW-1:0] loadAddr;
	logic [isaPkg::dataW-1:0] loadData;
	logic halted;
	logic err;
	logic retireValid;
	logic [isaPkg::regAddrW-1:0] retireReg;
	logic [isaPkg::dataW-1:0] retireData;
	int nChecks;
	int nMismatch;
	int nOther;
	int nAssert;
	isaPkg::instrWordT prog [progWords];

	proc u_dut (
		.clk(clk), .rst(rst), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.run(run), .halted(halted), .err(err), .retireValid(retireValid),
		.retireReg(retireReg), .retireData(retireData)
	);

	procChecker scoreboard (
		.clk(clk), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
		.loadData(loadData), .halted(halted), .err(err), .retireValid(retireValid),
		.retireReg(retireReg), .retireData(retireData),
		.nChecks(nChecks), .nMismatch(nMismatch), .nOther(nOther)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic isaPkg::instrWordT randomInstr();
		isaPkg::instrWordT w;
		logic [3:0] code;
		code = 4'($urandom_range(7, 0));
		w = 16'($urandom);
		w.iType.op = isaPkg::opT'(code);
		// Short forward branches only
		if (code == isaPkg::opBeqz)
			w.iType.imm = 6'($urandom_range(3, 0));
		return w;
	endfunction

	task automatic buildProgram(input int n);
		int ip;
		for (int a = 0; a < progWords; a++) begin
			if (a < bodyWords)
				prog[a] = randomInstr();
			else
				prog[a] = {isaPkg::opHalt, 12'h000};
		end
		if (n == illegalProg) begin
			ip = $urandom_range(34, 5);
			// Keep the trap reachable
			for (int k = ip - 3; k < ip; k++)
				if (prog[k].iType.op == isaPkg::opBeqz)
					prog[k].iType.op = isaPkg::opAdd;
			prog[ip] = {4'($urandom_range(15, 9)), 12'($urandom)};
		end
	endtask

	task automatic loadWord(input logic [7:0] a, input logic [15:0] d);
		@(negedge clk);
		loadEn = 1'b1;
		loadAddr = a;
		loadData = d;
	endtask

	task automatic loadProgram();
		for (int a = 0; a < progWords; a++)
			loadWord(8'(a), prog[a]);
		for (int a = memPkg::memDepth / 2; a < memPkg::memDepth; a++)
			loadWord(8'(a), 16'($urandom));
		@(negedge clk);
		loadEn = 1'b0;
	endtask

	task automatic pulseReset();
		@(negedge clk);
		rst = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b0;
	endtask

	initial begin
		void'($urandom(5903));
		rst = 1'b1;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		for (int n = 0; n < nProgs; n++) begin
			buildProgram(n);
			loadProgram();
			pulseReset();
			@(negedge clk);
			run = 1'b1;
			wait (halted === 1'b1);
			// Let older work and open handshakes drain
			repeat (20) @(negedge clk);
			run = 1'b0;
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		nAssert = u_dut.arbiter.arbChecks.nFail;
		$display("Programs %0d, checks %0d, mismatches %0d, other errors %0d, assertions %0d",
			nProgs, nChecks, nMismatch, nOther, nAssert);
		if (nMismatch == 0 && nOther == 0 && nAssert == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		#(watchdogNs);
		$display("Timeout: the programs did not all finish within %0d ns", watchdogNs);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: tb.f
hdl/isaPkg.sv
hdl/memPkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memStage.sv
hdl/memArbiter.sv
hdl/proc.sv
tb/procArb_assert.sv
tb/procChecker.sv
tb/procTb.sv
